// ==== include/ppu_defines.svh ====
// register map, vram layout and line geometry constants for the background ppu, included by rtl
`ifndef PPU_DEFINES_SVH
`define PPU_DEFINES_SVH

// memory-mapped register addresses
`define PPU_REG_LCDC 16'hFF40
`define PPU_REG_STAT 16'hFF41
`define PPU_REG_SCY  16'hFF42
`define PPU_REG_SCX  16'hFF43
`define PPU_REG_LY   16'hFF44
`define PPU_REG_LYC  16'hFF45
`define PPU_REG_DMA  16'hFF46
`define PPU_REG_BGP  16'hFF47
`define PPU_REG_OBP0 16'hFF48
`define PPU_REG_OBP1 16'hFF49
`define PPU_REG_WY   16'hFF4A
`define PPU_REG_WX   16'hFF4B

// vram layout
`define PPU_MAP0_BASE          16'h9800
`define PPU_MAP1_BASE          16'h9C00
`define PPU_TILE_BASE_UNSIGNED 16'h8000
`define PPU_TILE_BASE_SIGNED   16'h9000

// line and frame geometry
`define PPU_SCAN_DOTS     80
`define PPU_LINE_DOTS     456
`define PPU_VISIBLE_LINES 144
`define PPU_LAST_LINE     153
`define PPU_SCREEN_WIDTH  160

`define PPU_VRAM_LATENCY 1 // cycles from read strobe to valid data

`endif

// ==== rtl/ppu_reg_pkg.sv ====
// register-side types shared by the register block, line timer and fetcher
package ppu_reg_pkg;

    // lcdc bit layout, msb first
    typedef struct packed {
        logic enable;   // lcd on
        logic win_map;  // stored only
        logic win_en;   // stored only
        logic tile_sel; // 1 = unsigned tiles at 8000
        logic bg_map;   // 1 = map at 9c00
        logic obj_size; // stored only
        logic obj_en;   // stored only
        logic bg_en;    // 0 forces background pixels to 0
    } lcdc_t;

    // control bundle from the register block to the pipeline
    typedef struct packed {
        lcdc_t      lcdc;
        logic [7:0] scx;
        logic [7:0] scy;
    } ppu_ctrl_t;

endpackage

// ==== rtl/ppu_pipe_pkg.sv ====
// pipeline types for modes, fetch states, line status and tile rows
package ppu_pipe_pkg;

    // encoding matches the stat mode bits
    typedef enum logic [1:0] {
        MODE_HBLANK = 2'd0,
        MODE_VBLANK = 2'd1,
        MODE_SCAN   = 2'd2,
        MODE_DRAW   = 2'd3
    } ppu_mode_t;

    typedef enum logic [2:0] {
        FETCH_IDLE,
        FETCH_MAP,
        FETCH_LO,
        FETCH_HI,
        FETCH_HOLD
    } fetch_state_t;

    typedef struct packed {
        ppu_mode_t  mode;
        logic [7:0] ly;
        logic       draw_start; // first cycle of draw
    } line_status_t;

    // one tile row, two bit planes
    typedef struct packed {
        logic [7:0] lo;
        logic [7:0] hi;
    } tile_row_t;

endpackage

// ==== rtl/ppu_regs.sv ====
// ppu register block at ff40-ff4b: cpu access, stat assembly and interrupt levels
`include "ppu_defines.svh"

module ppu_regs
    import ppu_reg_pkg::*, ppu_pipe_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic [15:0]  addr,
    input  logic         wr,
    input  logic         rd,
    input  logic [7:0]   wdata,
    input  line_status_t status,
    output logic [7:0]   rdata,
    output ppu_ctrl_t    ctrl,
    output logic         irq_vblank,
    output logic         irq_stat
);

    lcdc_t      lcdc;
    logic [6:3] stat_en; // writable stat interrupt selects
    logic [7:0] scy;
    logic [7:0] scx;
    logic [7:0] lyc;
    logic [7:0] dma;
    logic [7:0] bgp;
    logic [7:0] obp0;
    logic [7:0] obp1;
    logic [7:0] wy;
    logic [7:0] wx;
    logic       coinc;

    assign coinc = (status.ly == lyc);

    always_ff @(posedge clk) begin
        if (rst) begin
            lcdc    <= '0;
            stat_en <= '0;
            scy     <= '0;
            scx     <= '0;
            lyc     <= '0;
            dma     <= '0;
            bgp     <= '0;
            obp0    <= '0;
            obp1    <= '0;
            wy      <= '0;
            wx      <= '0;
        end else if (wr) begin
            case (addr)
                `PPU_REG_LCDC: lcdc    <= lcdc_t'(wdata);
                `PPU_REG_STAT: stat_en <= wdata[6:3]; // low bits are status
                `PPU_REG_SCY:  scy     <= wdata;
                `PPU_REG_SCX:  scx     <= wdata;
                `PPU_REG_LYC:  lyc     <= wdata;
                `PPU_REG_DMA:  dma     <= wdata;
                `PPU_REG_BGP:  bgp     <= wdata;
                `PPU_REG_OBP0: obp0    <= wdata;
                `PPU_REG_OBP1: obp1    <= wdata;
                `PPU_REG_WY:   wy      <= wdata;
                `PPU_REG_WX:   wx      <= wdata;
                default: ; // ly and unmapped addresses ignore writes
            endcase
        end
    end

    always_comb begin
        rdata = 8'hFF;
        if (rd) begin
            case (addr)
                `PPU_REG_LCDC: rdata = lcdc;
                `PPU_REG_STAT: rdata = {1'b1, stat_en, coinc, status.mode};
                `PPU_REG_SCY:  rdata = scy;
                `PPU_REG_SCX:  rdata = scx;
                `PPU_REG_LY:   rdata = status.ly;
                `PPU_REG_LYC:  rdata = lyc;
                `PPU_REG_DMA:  rdata = dma;
                `PPU_REG_BGP:  rdata = bgp;
                `PPU_REG_OBP0: rdata = obp0;
                `PPU_REG_OBP1: rdata = obp1;
                `PPU_REG_WY:   rdata = wy;
                `PPU_REG_WX:   rdata = wx;
                default:       rdata = 8'hFF;
            endcase
        end
    end

    assign ctrl = '{lcdc: lcdc, scx: scx, scy: scy};

    assign irq_vblank = (status.mode == MODE_VBLANK);
    assign irq_stat   = (stat_en[6] && coinc)
                      | (stat_en[3] && status.mode == MODE_HBLANK)
                      | (stat_en[4] && status.mode == MODE_VBLANK)
                      | (stat_en[5] && status.mode == MODE_SCAN);

endmodule

// ==== rtl/ppu_line_timer.sv ====
// dot and line counter that sequences scan, draw, h-blank and v-blank modes
`include "ppu_defines.svh"

module ppu_line_timer
    import ppu_reg_pkg::*, ppu_pipe_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  ppu_ctrl_t    ctrl,
    input  logic         line_done,
    output line_status_t status,
    output ppu_mode_t    mode
);

    logic [8:0] dot;
    logic       running; // first enabled cycle loads line 0 dot 0
    logic       line_end;
    logic [7:0] ly_next;

    assign line_end = (dot == 9'(`PPU_LINE_DOTS - 1));
    assign ly_next  = (status.ly == 8'(`PPU_LAST_LINE)) ? 8'd0 : status.ly + 8'd1;
    assign mode     = status.mode;

    always_ff @(posedge clk) begin
        if (rst || !ctrl.lcdc.enable) begin
            running           <= 1'b0;
            dot               <= '0;
            status.ly         <= '0;
            status.mode       <= MODE_HBLANK; // lcd off
            status.draw_start <= 1'b0;
        end else if (!running) begin
            running           <= 1'b1;
            dot               <= '0;
            status.ly         <= '0;
            status.mode       <= MODE_SCAN;
            status.draw_start <= 1'b0;
        end else begin
            status.draw_start <= 1'b0;
            if (line_end) begin
                dot       <= '0;
                status.ly <= ly_next;
                status.mode <= (ly_next >= 8'(`PPU_VISIBLE_LINES)) ? MODE_VBLANK : MODE_SCAN;
            end else begin
                dot <= dot + 9'd1;
                case (status.mode)
                    MODE_SCAN: begin
                        if (dot == 9'(`PPU_SCAN_DOTS - 1)) begin
                            status.mode       <= MODE_DRAW;
                            status.draw_start <= 1'b1;
                        end
                    end
                    MODE_DRAW: begin
                        if (line_done) begin
                            status.mode <= MODE_HBLANK; // rest of the line idles
                        end
                    end
                    default: ; // blanking holds until line end
                endcase
            end
        end
    end

endmodule

// ==== rtl/ppu_bg_fetcher.sv ====
// background fetcher: reads map byte and both tile planes from vram into tile rows
`include "ppu_defines.svh"

module ppu_bg_fetcher
    import ppu_reg_pkg::*, ppu_pipe_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  ppu_ctrl_t    ctrl,
    input  line_status_t status,
    input  logic [7:0]   vram_data,
    input  logic         row_take,
    output logic         vram_rd,
    output logic [15:0]  vram_addr,
    output tile_row_t    row,
    output logic         row_ready
);

    fetch_state_t state;
    logic [1:0]   phase;      // cycles since the last strobe
    logic [4:0]   col;
    logic [4:0]   col_sel;
    logic [7:0]   tile_num;
    logic [7:0]   bg_y;
    logic [15:0]  map_base;
    logic [15:0]  map_addr;
    logic [15:0]  tile_addr;
    logic [15:0]  lo_addr;
    logic         in_draw;
    logic         data_phase;
    logic         issue_phase;
    logic         start_tile;

    assign in_draw     = (status.mode == MODE_DRAW);
    assign data_phase  = (phase == 2'(`PPU_VRAM_LATENCY - 1));
    assign issue_phase = (phase == 2'(`PPU_VRAM_LATENCY));
    assign start_tile  = (state == FETCH_HOLD) && row_take;

    assign bg_y    = status.ly + ctrl.scy; // wraps mod 256
    assign col_sel = status.draw_start ? ctrl.scx[7:3] :
                     start_tile        ? col + 5'd1    : col;

    assign map_base  = ctrl.lcdc.bg_map ? `PPU_MAP1_BASE : `PPU_MAP0_BASE;
    assign map_addr  = map_base + {6'd0, bg_y[7:3], col_sel};
    assign tile_addr = ctrl.lcdc.tile_sel ?
                       `PPU_TILE_BASE_UNSIGNED + {4'd0, tile_num, 4'd0} :
                       `PPU_TILE_BASE_SIGNED + {{4{tile_num[7]}}, tile_num, 4'd0};
    assign lo_addr   = tile_addr + {12'd0, bg_y[2:0], 1'b0};

    // the map read goes out on the same cycle as draw_start or the take
    always_comb begin
        vram_rd   = 1'b0;
        vram_addr = map_addr;
        if (in_draw) begin
            if (status.draw_start || start_tile) begin
                vram_rd = 1'b1;
            end else if (state == FETCH_MAP && issue_phase) begin
                vram_rd   = 1'b1;
                vram_addr = lo_addr;
            end else if (state == FETCH_LO && issue_phase) begin
                vram_rd   = 1'b1;
                vram_addr = lo_addr + 16'd1; // high plane
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || !in_draw) begin
            state     <= FETCH_IDLE;
            phase     <= '0;
            col       <= '0;
            row_ready <= 1'b0;
        end else begin
            col <= col_sel;
            if (status.draw_start) begin
                state     <= FETCH_MAP;
                phase     <= '0;
                row_ready <= 1'b0;
            end else begin
                case (state)
                    FETCH_MAP, FETCH_LO: begin
                        if (issue_phase) begin
                            state <= (state == FETCH_MAP) ? FETCH_LO : FETCH_HI;
                            phase <= '0;
                        end else begin
                            phase <= phase + 2'd1;
                        end
                    end
                    FETCH_HI: begin
                        if (data_phase) begin
                            state     <= FETCH_HOLD;
                            row_ready <= 1'b1;
                        end else begin
                            phase <= phase + 2'd1;
                        end
                    end
                    FETCH_HOLD: begin
                        if (row_take) begin
                            state     <= FETCH_MAP; // next map read already issued
                            phase     <= '0;
                            row_ready <= 1'b0;
                        end
                    end
                    default: ; // idle until draw_start
                endcase
            end
        end
    end

    // capture returned bytes
    always_ff @(posedge clk) begin
        if (in_draw && data_phase) begin
            case (state)
                FETCH_MAP: tile_num <= vram_data;
                FETCH_LO:  row.lo   <= ctrl.lcdc.bg_en ? vram_data : 8'd0;
                FETCH_HI:  row.hi   <= ctrl.lcdc.bg_en ? vram_data : 8'd0;
                default: ;
            endcase
        end
    end

endmodule

// ==== rtl/ppu_pixel_shifter.sv ====
// two-plane pixel shifter with fine-scroll discard and 160-pixel line count
`include "ppu_defines.svh"

module ppu_pixel_shifter
    import ppu_pipe_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  line_status_t status,
    input  logic [7:0]   scx,
    input  tile_row_t    row,
    input  logic         row_ready,
    output logic         row_take,
    output logic [1:0]   px,
    output logic         px_valid,
    output logic         line_done
);

    tile_row_t  shift_row;
    logic       active;    // line in progress
    logic [3:0] bits_left;
    logic [2:0] discard;   // fine scroll pixels still to drop
    logic [7:0] px_count;
    logic       shifting;
    logic       last_px;

    assign row_take = active && (bits_left == 4'd0) && row_ready;
    assign shifting = active && (bits_left != 4'd0);
    assign last_px  = (px_count == 8'(`PPU_SCREEN_WIDTH - 1));

    always_ff @(posedge clk) begin
        if (rst || status.mode != MODE_DRAW) begin
            active    <= 1'b0;
            bits_left <= '0;
            discard   <= '0;
            px_count  <= '0;
            px_valid  <= 1'b0;
            line_done <= 1'b0;
        end else if (status.draw_start) begin
            active    <= 1'b1;
            bits_left <= '0;
            discard   <= scx[2:0];
            px_count  <= '0;
            px_valid  <= 1'b0;
            line_done <= 1'b0;
        end else begin
            px_valid  <= 1'b0;
            line_done <= 1'b0;
            if (row_take) begin
                bits_left <= 4'd8;
            end else if (shifting) begin
                bits_left <= bits_left - 4'd1;
                if (discard != 3'd0) begin
                    discard <= discard - 3'd1; // dropped pixel
                end else begin
                    px_valid <= 1'b1;
                    px_count <= px_count + 8'd1;
                    if (last_px) begin
                        line_done <= 1'b1;
                        active    <= 1'b0; // idle until next draw_start
                    end
                end
            end
        end
    end

    // msb first, high plane bit on top
    always_ff @(posedge clk) begin
        if (row_take) begin
            shift_row <= row;
        end else if (shifting) begin
            shift_row.lo <= {shift_row.lo[6:0], 1'b0};
            shift_row.hi <= {shift_row.hi[6:0], 1'b0};
        end
        if (shifting) begin
            px <= {shift_row.hi[7], shift_row.lo[7]};
        end
    end

endmodule

// ==== rtl/ppu_top.sv ====
// top level of the background ppu, connects registers, timer, fetcher and shifter
module ppu_top
    import ppu_reg_pkg::*, ppu_pipe_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic [15:0] addr,
    input  logic        wr,
    input  logic        rd,
    input  logic [7:0]  wdata,
    output logic [7:0]  rdata,
    output logic        vram_rd,
    output logic [15:0] vram_addr,
    input  logic [7:0]  vram_data,
    output logic        irq_vblank,
    output logic        irq_stat,
    output ppu_mode_t   mode,
    output logic [1:0]  px,
    output logic        px_valid
);

    ppu_ctrl_t    ctrl;
    line_status_t status;
    tile_row_t    row;
    logic         row_ready;
    logic         row_take;
    logic         line_done;

    ppu_regs regs0 (
        .clk        (clk),
        .rst        (rst),
        .addr       (addr),
        .wr         (wr),
        .rd         (rd),
        .wdata      (wdata),
        .status     (status),
        .rdata      (rdata),
        .ctrl       (ctrl),
        .irq_vblank (irq_vblank),
        .irq_stat   (irq_stat)
    );

    ppu_line_timer timer0 (
        .clk       (clk),
        .rst       (rst),
        .ctrl      (ctrl),
        .line_done (line_done),
        .status    (status),
        .mode      (mode)
    );

    ppu_bg_fetcher fetch0 (
        .clk       (clk),
        .rst       (rst),
        .ctrl      (ctrl),
        .status    (status),
        .vram_data (vram_data),
        .row_take  (row_take),
        .vram_rd   (vram_rd),
        .vram_addr (vram_addr),
        .row       (row),
        .row_ready (row_ready)
    );

    ppu_pixel_shifter shift0 (
        .clk       (clk),
        .rst       (rst),
        .status    (status),
        .scx       (ctrl.scx),
        .row       (row),
        .row_ready (row_ready),
        .row_take  (row_take),
        .px        (px),
        .px_valid  (px_valid),
        .line_done (line_done)
    );

endmodule

// ==== testbench/ppu_vram_model.sv ====
// behavioral vram for the testbench, fixed read latency, preloaded through a write port
`include "ppu_defines.svh"

module ppu_vram_model (
    input  logic        clk,
    input  logic        we,
    input  logic [12:0] waddr,
    input  logic [7:0]  wdata,
    input  logic        rd,
    input  logic [15:0] addr,
    output logic [7:0]  data
);

    logic [7:0] mem [0:8191];                    // 8000-9fff
    logic [7:0] pipe [0:`PPU_VRAM_LATENCY-1];    // read data in flight

    assign data = pipe[`PPU_VRAM_LATENCY-1];

    always @(posedge clk) begin : read_pipe
        int i;
        if (we) begin
            mem[waddr] <= wdata;
        end
        pipe[0] <= rd ? mem[addr[12:0]] : 8'hxx; // no strobe, no valid data
        for (i = 1; i < `PPU_VRAM_LATENCY; i++) begin
            pipe[i] <= pipe[i-1];
        end
    end

endmodule

// ==== testbench/ppu_tb.sv ====
// directed testbench for the background ppu, runs register, timing, pixel and interrupt tests
`include "ppu_defines.svh"

module ppu_tb
    import ppu_pipe_pkg::*;
();

    localparam int WAIT_LIMIT  = 1000;
    localparam int FRAME_LIMIT = (`PPU_LAST_LINE + 1) * `PPU_LINE_DOTS + 1000;

    logic        clk = 1'b0;
    logic        rst;
    logic [15:0] addr;
    logic        wr;
    logic        rd;
    logic [7:0]  wdata;
    logic [7:0]  rdata;
    logic        vram_rd;
    logic [15:0] vram_addr;
    logic [7:0]  vram_data;
    logic        vram_we;
    logic [12:0] vram_waddr;
    logic [7:0]  vram_wdata;
    logic        irq_vblank;
    logic        irq_stat;
    ppu_mode_t   mode;
    logic [1:0]  px;
    logic        px_valid;

    logic [7:0]  vram_ref [0:8191]; // copy of what was preloaded
    integer      seed = 69591;
    int          cycle = 0;
    int          check_count = 0;
    int          err_count = 0;
    int          timeout_count = 0;

    always #5 clk = ~clk;
    always @(posedge clk) cycle <= cycle + 1;

    ppu_top dut0 (
        .clk(clk), .rst(rst), .addr(addr), .wr(wr), .rd(rd), .wdata(wdata), .rdata(rdata),
        .vram_rd(vram_rd), .vram_addr(vram_addr), .vram_data(vram_data),
        .irq_vblank(irq_vblank), .irq_stat(irq_stat), .mode(mode), .px(px), .px_valid(px_valid)
    );

    ppu_vram_model vram0 (
        .clk(clk), .we(vram_we), .waddr(vram_waddr), .wdata(vram_wdata),
        .rd(vram_rd), .addr(vram_addr), .data(vram_data)
    );

    task automatic check_value(input string name, input int expected, input int actual);
        check_count++;
        assert (actual == expected) else begin
            $display("CHECK FAILED %s: expected %0h, actual %0h", name, expected, actual);
            err_count++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s", what);
        timeout_count++;
    endtask

    task automatic write_reg(input logic [15:0] a, input logic [7:0] d);
        @(posedge clk);
        addr  <= a;
        wdata <= d;
        wr    <= 1'b1;
        @(posedge clk);
        wr    <= 1'b0;
    endtask

    task automatic read_reg(input logic [15:0] a, output logic [7:0] d);
        @(posedge clk);
        addr <= a;
        rd   <= 1'b1;
        @(negedge clk);
        d = rdata;
        @(posedge clk);
        rd   <= 1'b0;
    endtask

    task automatic preload_vram();
        int i;
        logic [7:0] val;
        for (i = 0; i < 8192; i++) begin
            val = $random(seed);
            vram_ref[i] = val;
            @(posedge clk);
            vram_we    <= 1'b1;
            vram_waddr <= 13'(i);
            vram_wdata <= val;
        end
        @(posedge clk);
        vram_we <= 1'b0;
    endtask

    task automatic wait_mode(input ppu_mode_t m, input string what);
        int t;
        t = 0;
        @(negedge clk);
        while (mode != m && t < WAIT_LIMIT) begin
            @(negedge clk);
            t++;
        end
        if (mode != m) begin
            report_timeout(what);
        end
    endtask

    task automatic wait_change(output ppu_mode_t m);
        ppu_mode_t prev;
        int t;
        t = 0;
        @(negedge clk);
        prev = mode;
        while (mode == prev && t < WAIT_LIMIT) begin
            @(negedge clk);
            t++;
        end
        if (mode == prev) begin
            report_timeout("a mode change");
        end
        m = mode;
    endtask

    task automatic wait_ly(input logic [7:0] v);
        int t;
        t = 0;
        @(posedge clk);
        addr <= `PPU_REG_LY;
        rd   <= 1'b1;
        @(negedge clk);
        while (rdata != v && t < 2 * `PPU_LINE_DOTS) begin
            @(negedge clk);
            t++;
        end
        if (rdata != v) begin
            report_timeout("LY to reach the compare value");
        end
        @(posedge clk);
        rd <= 1'b0;
    endtask

    // reference pixel from the preloaded map and tiles
    function automatic logic [1:0] expect_px(input logic [7:0] ly, input logic [7:0] x,
            input logic [7:0] scx, input logic [7:0] scy, input logic [7:0] lcdc);
        logic [7:0] bg_x;
        logic [7:0] bg_y;
        logic [7:0] tile;
        logic [7:0] lo;
        logic [7:0] hi;
        int         map_a;
        int         lo_a;
        bg_x  = x + scx;
        bg_y  = ly + scy;
        map_a = (lcdc[3] ? `PPU_MAP1_BASE : `PPU_MAP0_BASE) + 32 * bg_y[7:3] + bg_x[7:3];
        tile  = vram_ref[map_a - 'h8000];
        if (lcdc[4]) begin
            lo_a = `PPU_TILE_BASE_UNSIGNED + 16 * tile;
        end else begin
            lo_a = `PPU_TILE_BASE_SIGNED + 16 * int'($signed(tile)); // 8800-97ff
        end
        lo_a = lo_a + 2 * bg_y[2:0];
        lo   = vram_ref[lo_a - 'h8000];
        hi   = vram_ref[lo_a + 1 - 'h8000];
        return lcdc[0] ? {hi[7 - bg_x[2:0]], lo[7 - bg_x[2:0]]} : 2'b00;
    endfunction

    // lines start at 0 because every caller has just turned the lcd on
    task automatic check_lines(input string name, input int nlines, input logic [7:0] scx,
            input logic [7:0] scy, input logic [7:0] lcdc);
        logic [7:0] ly;
        logic       rd_prev;
        int l;
        int n;
        int t;
        for (l = 0; l < nlines; l++) begin
            wait_mode(MODE_SCAN, "mode SCAN");
            read_reg(`PPU_REG_LY, ly);
            check_value({name, " ly"}, l, ly);
            wait_mode(MODE_DRAW, "mode DRAW");
            n = 0;
            t = 0;
            rd_prev = vram_rd;
            while (mode == MODE_DRAW && t < `PPU_LINE_DOTS) begin
                @(negedge clk);
                t++;
                check_value({name, " vram_rd spacing"}, 0, vram_rd && rd_prev);
                rd_prev = vram_rd;
                if (px_valid) begin
                    check_value($sformatf("%s ly %0d x %0d", name, l, n),
                                expect_px(8'(l), 8'(n), scx, scy, lcdc), px);
                    n++;
                end
            end
            if (mode == MODE_DRAW) begin
                report_timeout("the end of DRAW");
            end
            check_value({name, " pixel count"}, `PPU_SCREEN_WIDTH, n);
        end
    endtask

    task automatic reset_test();
        logic [7:0] d;
        @(negedge clk);
        check_value("reset vram_rd", 0, vram_rd);
        check_value("reset px_valid", 0, px_valid);
        check_value("reset irq_vblank", 0, irq_vblank);
        check_value("reset irq_stat", 0, irq_stat);
        check_value("reset mode", MODE_HBLANK, mode);
        read_reg(`PPU_REG_LCDC, d);
        check_value("reset lcdc", 0, d);
    endtask

    task automatic register_test();
        logic [7:0] vals [12];
        logic [7:0] d;
        logic [7:0] stat_w;
        int i;
        for (i = 0; i < 12; i++) begin
            vals[i] = $random(seed);
        end
        vals[0][7] = 1'b0; // lcd stays off
        for (i = 0; i < 12; i++) begin
            if (i != 1 && i != 4) begin
                write_reg(16'(`PPU_REG_LCDC + i), vals[i]);
            end
        end
        for (i = 0; i < 12; i++) begin
            if (i != 1 && i != 4) begin
                read_reg(16'(`PPU_REG_LCDC + i), d);
                check_value($sformatf("register access %h", `PPU_REG_LCDC + i), vals[i], d);
            end
        end
        stat_w = $random(seed);
        write_reg(`PPU_REG_STAT, stat_w);
        read_reg(`PPU_REG_STAT, d);
        check_value("register access stat", {1'b1, stat_w[6:3], vals[5] == 8'd0, 2'b00}, d);
        write_reg(`PPU_REG_LY, 8'h5A);
        read_reg(`PPU_REG_LY, d);
        check_value("register access ly write", 0, d);
        read_reg(16'hFF4C, d);
        check_value("register access unmapped", 8'hFF, d);
    endtask

    task automatic mode_sequence_test();
        ppu_mode_t  m;
        logic [7:0] ly;
        int         t_prev;
        int         i;
        write_reg(`PPU_REG_LCDC, 8'h00);
        write_reg(`PPU_REG_LCDC, 8'h91);
        wait_mode(MODE_SCAN, "first SCAN");
        t_prev = cycle;
        read_reg(`PPU_REG_LY, ly);
        check_value("mode sequence first ly", 0, ly);
        for (i = 0; i < 3; i++) begin
            wait_change(m);
            check_value("mode sequence after scan", MODE_DRAW, m);
            wait_change(m);
            check_value("mode sequence after draw", MODE_HBLANK, m);
            wait_change(m);
            check_value("mode sequence after hblank", MODE_SCAN, m);
            check_value("mode sequence line length", `PPU_LINE_DOTS, cycle - t_prev);
            t_prev = cycle;
            read_reg(`PPU_REG_LY, ly);
            check_value("mode sequence ly step", i + 1, ly);
        end
    endtask

    task automatic pixel_test();
        write_reg(`PPU_REG_LCDC, 8'h00);
        write_reg(`PPU_REG_SCX, 8'h00);
        write_reg(`PPU_REG_SCY, 8'h00);
        write_reg(`PPU_REG_LCDC, 8'h91); // on, unsigned tiles, map 0, bg on
        check_lines("pixel content", 4, 8'h00, 8'h00, 8'h91);
    endtask

    task automatic scroll_test();
        logic [7:0] scx;
        logic [7:0] scy;
        scx = $random(seed);
        scy = $random(seed);
        if (scx[2:0] == 3'd0) begin
            scx = scx + 8'd3; // make sure some pixels are discarded
        end
        write_reg(`PPU_REG_LCDC, 8'h00);
        write_reg(`PPU_REG_SCX, scx);
        write_reg(`PPU_REG_SCY, scy);
        write_reg(`PPU_REG_LCDC, 8'h89); // signed tiles, map 1
        check_lines("scroll signed map1", 3, scx, scy, 8'h89);
        write_reg(`PPU_REG_LCDC, 8'h00);
        write_reg(`PPU_REG_LCDC, 8'h88);
        check_lines("bg disabled", 2, scx, scy, 8'h88);
    endtask

    task automatic frame_irq_test();
        logic [7:0] lyc;
        logic [7:0] ly;
        logic [7:0] ly_prev;
        logic [7:0] d;
        int         t;
        int         i;
        bit         wrapped;
        lyc = 8'($unsigned($random(seed)) % `PPU_VISIBLE_LINES);
        write_reg(`PPU_REG_LCDC, 8'h00);
        write_reg(`PPU_REG_LYC, lyc);
        write_reg(`PPU_REG_STAT, 8'h40); // coincidence interrupt only
        write_reg(`PPU_REG_LCDC, 8'h91);
        @(posedge clk);
        addr <= `PPU_REG_LY;
        rd   <= 1'b1;
        @(negedge clk);
        ly_prev = rdata;
        t = 0;
        wrapped = 1'b0;
        while (!wrapped && t < FRAME_LIMIT) begin
            @(negedge clk);
            t++;
            ly = rdata;
            if (ly != ly_prev && ly_prev == 8'(`PPU_LAST_LINE)) begin
                check_value("frame ly wrap", 0, ly);
                wrapped = 1'b1;
            end else if (ly != ly_prev) begin
                check_value("frame ly step", int'(ly_prev) + 1, ly);
            end
            check_value("frame irq_vblank", ly >= `PPU_VISIBLE_LINES, irq_vblank);
            check_value("frame irq_stat", ly == lyc, irq_stat);
            ly_prev = ly;
        end
        if (!wrapped) begin
            report_timeout("LY to wrap to 0");
        end
        @(posedge clk);
        rd <= 1'b0;
        write_reg(`PPU_REG_LYC, 8'd2);
        read_reg(`PPU_REG_STAT, d);
        check_value("stat coincidence low", 0, d[2]);
        wait_ly(8'd2);
        read_reg(`PPU_REG_STAT, d);
        check_value("stat coincidence high", 1, d[2]);
        @(negedge clk);
        check_value("irq_stat on coincidence", 1, irq_stat);
        write_reg(`PPU_REG_LCDC, 8'h00);
        @(posedge clk);
        for (i = 0; i < 500; i++) begin
            @(negedge clk);
            check_value("lcd off mode", MODE_HBLANK, mode);
            check_value("lcd off px_valid", 0, px_valid);
        end
        read_reg(`PPU_REG_LY, d);
        check_value("lcd off ly", 0, d);
    endtask

    initial begin
        rst        = 1'b1;
        addr       = '0;
        wr         = 1'b0;
        rd         = 1'b0;
        wdata      = '0;
        vram_we    = 1'b0;
        vram_waddr = '0;
        vram_wdata = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        reset_test();
        preload_vram();
        register_test();
        mode_sequence_test();
        pixel_test();
        scroll_test();
        frame_irq_test();
        $display("checks %0d, errors %0d, timeouts %0d", check_count, err_count, timeout_count);
        if (err_count == 0 && timeout_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+include
rtl/ppu_reg_pkg.sv
rtl/ppu_pipe_pkg.sv
rtl/ppu_regs.sv
rtl/ppu_line_timer.sv
rtl/ppu_bg_fetcher.sv
rtl/ppu_pixel_shifter.sv
rtl/ppu_top.sv
testbench/ppu_vram_model.sv
testbench/ppu_tb.sv
